// ==== run.sh ====
#!/bin/sh
verilator --binary -Wno-fatal --top-module tb_top -f sources.f -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== sim/tb_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_cfg.svh"

module tb_checker (
	input wire logic                 i_clk,
	input wire logic                 i_write,
	input wire logic                 i_ok,
	input wire logic [`CPU_XLEN-1:0] i_addr,
	input wire logic [`CPU_XLEN-1:0] i_data
);

	logic [`CPU_XLEN-1:0] exp_addr [$];
	logic [`CPU_XLEN-1:0] exp_data [$];
	int next_idx = 0;
	int ok_cnt = 0;
	int err_cnt = 0;

	task automatic add_expected(input logic [`CPU_XLEN-1:0] a, input logic [`CPU_XLEN-1:0] d);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	function automatic int n_expected();
		return exp_addr.size();
	endfunction

	// called once the core has reached its halt loop
	task automatic check_all_seen();
		if (next_idx < exp_addr.size()) begin
			$display("missing stores: only %0d of %0d expected stores were seen",
				next_idx, exp_addr.size());
			err_cnt++;
		end
	endtask

	// a store completes on the edge where i_ok is high
	always @(posedge i_clk) begin
		if (i_write && i_ok) begin
			if (next_idx >= exp_addr.size()) begin
				$display("unexpected extra store to %h (data %h) at %0t", i_addr, i_data, $time);
				err_cnt++;
			end else if (i_addr !== exp_addr[next_idx] || i_data !== exp_data[next_idx]) begin
				$display("MISMATCH at %0t: store %0d expected [%h] = %h, got [%h] = %h",
					$time, next_idx, exp_addr[next_idx], exp_data[next_idx], i_addr, i_data);
				err_cnt++;
				next_idx++;
			end else begin
				$display("store %0d ok: [%h] = %h", next_idx, i_addr, i_data);
				ok_cnt++;
				next_idx++;
			end
		end
	end

endmodule

`default_nettype wire

// ==== sim/tb_input.txt ====
# M <address> <word> : preload memory (program and data)
# E <address> <data> : expected store, in program order
M 08000000 E3A0A408  mov r10, #0x08000000
M 08000004 E28AAB02  add r10, r10, #0x800
M 08000008 E3B01005  movs r1, #5
M 0800000C E2912003  adds r2, r1, #3
M 08000010 E2513007  subs r3, r1, #7
M 08000014 E2714009  rsbs r4, r1, #9
M 08000018 E2B15010  adcs r5, r1, #0x10
M 0800001C E2D16002  sbcs r6, r1, #2
M 08000020 23A07001  movcs r7, #1
M 08000024 33A07000  movcc r7, #0
M 08000028 E58A2000  str r2, [r10, #0x00]
M 0800002C E58A3004  str r3, [r10, #0x04]
M 08000030 E58A4008  str r4, [r10, #0x08]
M 08000034 E58A500C  str r5, [r10, #0x0c]
M 08000038 E58A6010  str r6, [r10, #0x10]
M 0800003C E58A7014  str r7, [r10, #0x14]
M 08000040 E3510005  cmp r1, #5
M 08000044 03A080AA  moveq r8, #0xaa
M 08000048 13A08055  movne r8, #0x55
M 0800004C E58A8018  str r8, [r10, #0x18]
M 08000050 23A08011  movcs r8, #0x11
M 08000054 33A08022  movcc r8, #0x22
M 08000058 E58A801C  str r8, [r10, #0x1c]
M 0800005C E3510009  cmp r1, #9
M 08000060 43A08033  movmi r8, #0x33
M 08000064 A3A08044  movge r8, #0x44
M 08000068 E58A8020  str r8, [r10, #0x20]
M 0800006C B3A08066  movlt r8, #0x66
M 08000070 E58A8024  str r8, [r10, #0x24]
M 08000074 E3A00106  mov r0, #0x80000001
M 08000078 E58A0028  str r0, [r10, #0x28]
M 0800007C E1A0B200  mov r11, r0, lsl #4
M 08000080 E58AB02C  str r11, [r10, #0x2c]
M 08000084 E1A0B220  mov r11, r0, lsr #4
M 08000088 E58AB030  str r11, [r10, #0x30]
M 0800008C E1A0B240  mov r11, r0, asr #4
M 08000090 E58AB034  str r11, [r10, #0x34]
M 08000094 E1A0B260  mov r11, r0, ror #4
M 08000098 E58AB038  str r11, [r10, #0x38]
M 0800009C E1B0B020  movs r11, r0, lsr #32
M 080000A0 E58AB03C  str r11, [r10, #0x3c]
M 080000A4 E1A0B040  mov r11, r0, asr #32
M 080000A8 E58AB040  str r11, [r10, #0x40]
M 080000AC E1A0B060  mov r11, r0, rrx
M 080000B0 E58AB044  str r11, [r10, #0x44]
M 080000B4 E200B0FF  and r11, r0, #0xff
M 080000B8 E58AB048  str r11, [r10, #0x48]
M 080000BC E020B001  eor r11, r0, r1
M 080000C0 E58AB04C  str r11, [r10, #0x4c]
M 080000C4 E381B030  orr r11, r1, #0x30
M 080000C8 E58AB050  str r11, [r10, #0x50]
M 080000CC E3C0B001  bic r11, r0, #1
M 080000D0 E58AB054  str r11, [r10, #0x54]
M 080000D4 E3E0B000  mvn r11, #0
M 080000D8 E58AB058  str r11, [r10, #0x58]
M 080000DC E3110102  tst r1, #0x80000000
M 080000E0 23A0B0C1  movcs r11, #0xc1
M 080000E4 33A0B0C0  movcc r11, #0xc0
M 080000E8 E58AB05C  str r11, [r10, #0x5c]
M 080000EC E28A9C01  add r9, r10, #0x100
M 080000F0 E5B92004  ldr r2, [r9, #4]!
M 080000F4 E58A2060  str r2, [r10, #0x60]
M 080000F8 E58A9064  str r9, [r10, #0x64]
M 080000FC E4891004  str r1, [r9], #4
M 08000100 E58A9068  str r9, [r10, #0x68]
M 08000104 E5194008  ldr r4, [r9, #-8]
M 08000108 E58A406C  str r4, [r10, #0x6c]
M 0800010C E4195004  ldr r5, [r9], #-4
M 08000110 E58A5070  str r5, [r10, #0x70]
M 08000114 E58A9074  str r9, [r10, #0x74]
M 08000118 EA000000  b over the next store
M 0800011C E58A107C  str r1, [r10, #0x7c] never runs
M 08000120 EB000001  bl to 0x0800012c
M 08000124 E58A1078  str r1, [r10, #0x78]
M 08000128 EAFFFFFE  halt loop
M 0800012C E58AE07C  str lr, [r10, #0x7c]
M 08000130 E1A0F00E  mov pc, lr
M 08000900 11111111  load data
M 08000904 22222222
M 08000908 33333333
E 08000800 00000008
E 08000804 FFFFFFFE
E 08000808 00000004
E 0800080C 00000016
E 08000810 00000002
E 08000814 00000001
E 08000818 000000AA
E 0800081C 00000011
E 08000820 00000033
E 08000824 00000066
E 08000828 80000001
E 0800082C 00000010
E 08000830 08000000
E 08000834 F8000000
E 08000838 18000000
E 0800083C 00000000
E 08000840 FFFFFFFF
E 08000844 C0000000
E 08000848 00000001
E 0800084C 80000004
E 08000850 00000035
E 08000854 80000000
E 08000858 FFFFFFFF
E 0800085C 000000C1
E 08000860 22222222
E 08000864 08000904
E 08000904 00000005
E 08000868 08000908
E 0800086C 11111111
E 08000870 33333333
E 08000874 08000904
E 0800087C 08000124
E 08000878 00000005

// ==== sim/tb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_cfg.svh"

module tb_top;

	localparam int MEM_WORDS = 1024;
	localparam int MAX_WAIT = 3;
	localparam logic [`CPU_XLEN-1:0] HALT_INSTR = 32'hEAFF_FFFE;	// b to itself

	logic                 clk;
	logic                 rstn;
	logic [`CPU_XLEN-1:0] mem_addr;
	logic [`CPU_XLEN-1:0] mem_wdata;
	logic [`CPU_XLEN-1:0] mem_rdata;
	logic                 mem_read;
	logic                 mem_write;
	logic                 mem_ok;
	logic [`CPU_XLEN-1:0] mem [MEM_WORDS];

	integer   seed;
	int       draw;
	int       n_instr;
	int       cycle_limit;
	int       cycles;
	logic     busy;
	logic [1:0] wait_left;
	bit       load_ok;

	cpu_top uut (
		.clk(clk),
		.rstn(rstn),
		.o_mem_addr(mem_addr),
		.o_mem_wdata(mem_wdata),
		.i_mem_rdata(mem_rdata),
		.o_mem_read(mem_read),
		.o_mem_write(mem_write),
		.i_mem_ok(mem_ok)
	);

	tb_checker chk (
		.i_clk(clk),
		.i_write(mem_write),
		.i_ok(mem_ok),
		.i_addr(mem_addr),
		.i_data(mem_wdata)
	);

	always #10 clk = ~clk;

	function automatic int word_index(input logic [`CPU_XLEN-1:0] a);
		return int'(a[11:2]);	// wraps at MEM_WORDS
	endfunction

	// M records preload memory, E records are the expected stores in order
	task automatic load_input(output bit ok);
		int fd;
		int code;
		string line;
		logic [7:0] kind;
		logic [`CPU_XLEN-1:0] a;
		logic [`CPU_XLEN-1:0] d;
		ok = 1'b0;
		fd = $fopen("sim/tb_input.txt", "r");
		if (fd != 0) begin
			while ($fgets(line, fd) != 0) begin
				code = $sscanf(line, "%c %h %h", kind, a, d);
				if (code == 3 && kind == "M") begin
					mem[word_index(a)] <= d;
					n_instr++;
				end else if (code == 3 && kind == "E") begin
					chk.add_expected(a, d);
				end
			end
			$fclose(fd);
			ok = 1'b1;
		end
	endtask

	task automatic finish_run();
		chk.check_all_seen();
		$display("stores: %0d ok, %0d errors, %0d expected",
			chk.ok_cnt, chk.err_cnt, chk.n_expected());
		if (chk.err_cnt == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	endtask

	initial begin
		clk = 1'b0;
		rstn <= 1'b0;
		mem_ok <= 1'b0;
		mem_rdata <= '0;
		cycles <= 0;
		seed = 40102;
		n_instr = 0;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] <= 32'h5A5A_0000 ^ (32'(i) << 2);	// background pattern
		load_input(load_ok);
		if (!load_ok) begin
			$display("could not open the stimulus file sim/tb_input.txt");
			$display("CHECKS FAILED");
			$finish;
		end else begin
			cycle_limit = 4 * n_instr * (3 + MAX_WAIT);
			repeat (2) @(posedge clk);
			rstn <= 1'b1;
		end
	end

	// memory model with a random number of wait cycles per access
	always @(posedge clk) begin
		if (!rstn) begin
			mem_ok <= 1'b0;
			busy <= 1'b0;
		end else if (mem_ok) begin
			mem_ok <= 1'b0;
			busy <= 1'b0;
		end else if (mem_read || mem_write) begin
			if (busy && wait_left != 2'd0) begin
				wait_left <= wait_left - 2'd1;
			end else begin
				if (!busy)
					draw = $random(seed);
				if (busy || draw[1:0] == 2'd0) begin
					mem_ok <= 1'b1;
					if (mem_write)
						mem[word_index(mem_addr)] <= mem_wdata;
					else
						mem_rdata <= mem[word_index(mem_addr)];
				end else begin
					wait_left <= draw[1:0] - 2'd1;	// first wait cycle is this one
					busy <= 1'b1;
				end
			end
		end
	end

	// end of program or timeout
	always @(posedge clk) begin
		if (rstn)
			cycles <= cycles + 1;
		if (rstn && mem_read && mem_ok && mem_rdata == HALT_INSTR) begin
			finish_run();
		end else if (rstn && cycles >= cycle_limit) begin
			$display("timeout: the core stalled and did not reach its halt loop in %0d cycles",
				cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+src
src/cpu_pkg.sv
src/exec_if.sv
src/barrel_shifter.sv
src/alu_unit.sv
src/reg_file.sv
src/cpu_ctrl.sv
src/cpu_top.sv
sim/tb_checker.sv
sim/tb_top.sv

// ==== src/alu_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_unit import cpu_pkg::*; (
	exec_if.alu ex
);

	word_t       op_b;
	logic        sh_carry;
	word_t       add_x, add_y;
	logic        add_cin;
	logic [32:0] sum;
	logic        add_v;
	logic        arith;
	word_t       res;
	flags_t      fl;

	barrel_shifter u_shift (
		.i_imm_sel(ex.imm_sel),
		.i_imm8(ex.imm8),
		.i_rot(ex.rot),
		.i_rm_val(ex.rm_val),
		.i_shift_type(ex.shift_type),
		.i_shift_amt(ex.shift_amt),
		.i_carry_in(ex.flags_in[FLAG_C]),
		.o_operand(op_b),
		.o_carry(sh_carry)
	);

	// subtraction as x + ~y + 1, reverse forms swap inputs
	always_comb begin
		add_x = ex.op_a;
		add_y = op_b;
		add_cin = 1'b0;
		case (ex.op)
			SUB, CMP: begin add_y = ~op_b; add_cin = 1'b1; end
			RSB: begin add_x = op_b; add_y = ~ex.op_a; add_cin = 1'b1; end
			ADC: add_cin = ex.flags_in[FLAG_C];
			SBC: begin add_y = ~op_b; add_cin = ex.flags_in[FLAG_C]; end
			RSC: begin add_x = op_b; add_y = ~ex.op_a; add_cin = ex.flags_in[FLAG_C]; end
			default: ;
		endcase
	end

	assign sum = {1'b0, add_x} + {1'b0, add_y} + 33'(add_cin);
	assign add_v = (add_x[31] == add_y[31]) && (sum[31] != add_x[31]);

	always_comb begin
		arith = 1'b0;
		case (ex.op)
			AND, TST: res = ex.op_a & op_b;
			EOR, TEQ: res = ex.op_a ^ op_b;
			ORR:      res = ex.op_a | op_b;
			MOV:      res = op_b;
			BIC:      res = ex.op_a & ~op_b;
			MVN:      res = ~op_b;
			default: begin
				res = sum[31:0];
				arith = 1'b1;
			end
		endcase
		fl[FLAG_N] = res[31];
		fl[FLAG_Z] = res == '0;
		fl[FLAG_C] = arith ? sum[32] : sh_carry;
		fl[FLAG_V] = arith ? add_v : ex.flags_in[FLAG_V];	// logic ops keep v
	end

	assign ex.result = res;
	assign ex.flags_out = fl;
	assign ex.writes_rd = !(ex.op inside {TST, TEQ, CMP, CMN});

endmodule

`default_nettype wire

// ==== src/barrel_shifter.sv ====
`timescale 1ns/10ps
`default_nettype none

module barrel_shifter import cpu_pkg::*; (
	input  wire logic       i_imm_sel,
	input  wire logic [7:0] i_imm8,
	input  wire logic [3:0] i_rot,
	input  wire word_t      i_rm_val,
	input  wire shift_t     i_shift_type,
	input  wire logic [4:0] i_shift_amt,
	input  wire logic       i_carry_in,
	output word_t           o_operand,
	output logic            o_carry
);

	function automatic word_t ror32(input word_t v, input logic [4:0] n);
		logic [63:0] dbl;
		dbl = {v, v} >> n;
		return dbl[31:0];
	endfunction

	logic [32:0]        lsl_w;	// bit 32 is the last bit out
	logic [32:0]        lsr_w;	// bit 0 is the last bit out
	logic signed [32:0] asr_w;
	word_t              ror_w;
	word_t              imm_w;

	assign imm_w = ror32(word_t'(i_imm8), {i_rot, 1'b0});
	assign lsl_w = {1'b0, i_rm_val} << i_shift_amt;
	assign lsr_w = {i_rm_val, 1'b0} >> i_shift_amt;
	assign asr_w = $signed({i_rm_val, 1'b0}) >>> i_shift_amt;
	assign ror_w = ror32(i_rm_val, i_shift_amt);

	always_comb begin
		if (i_imm_sel) begin
			o_operand = imm_w;
			o_carry = (i_rot == 4'd0) ? i_carry_in : imm_w[31];
		end else begin
			case (i_shift_type)
				LSL: begin
					o_operand = lsl_w[31:0];
					o_carry = (i_shift_amt == 5'd0) ? i_carry_in : lsl_w[32];
				end
				LSR: begin
					o_operand = (i_shift_amt == 5'd0) ? '0 : lsr_w[32:1];	// #0 means #32
					o_carry = (i_shift_amt == 5'd0) ? i_rm_val[31] : lsr_w[0];
				end
				ASR: begin
					o_operand = (i_shift_amt == 5'd0) ? {32{i_rm_val[31]}} : asr_w[32:1];
					o_carry = (i_shift_amt == 5'd0) ? i_rm_val[31] : asr_w[0];
				end
				default: begin
					if (i_shift_amt == 5'd0) begin
						o_operand = {i_carry_in, i_rm_val[31:1]};	// rrx
						o_carry = i_rm_val[0];
					end else begin
						o_operand = ror_w;
						o_carry = ror_w[31];
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data and address width of the core
`define CPU_XLEN 32

// architectural registers, pc included
`define CPU_NREGS 16

// first fetch address after the init state
`define CPU_RESET_PC 32'h0800_0000

`endif

// ==== src/cpu_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_ctrl import cpu_pkg::*; (
	input  wire logic     clk,
	input  wire logic     rstn,
	output word_t         o_mem_addr,
	output word_t         o_mem_wdata,
	input  wire word_t    i_mem_rdata,
	output logic          o_mem_read,
	output logic          o_mem_write,
	input  wire logic     i_mem_ok,
	output reg_idx_t      o_rn_addr,
	output reg_idx_t      o_rm_addr,
	output reg_idx_t      o_rd_addr,
	input  wire word_t    i_rn_data,
	input  wire word_t    i_rm_data,
	input  wire word_t    i_rd_data,
	output logic          o_we,
	output reg_idx_t      o_waddr,
	output word_t         o_wdata,
	output word_t         o_pc,
	exec_if.ctrl          ex
);

	cpu_state_t state;
	word_t      instr;
	word_t      pc;
	word_t      ls_addr;	// access address, frozen before writeback
	flags_t     flags;

	logic     cond_ok, is_dp, is_br, is_ls;
	logic     ls_p, ls_u, ls_w, ls_l;
	logic     rd_is_pc, set_flags;
	reg_idx_t rn, rd;
	word_t    off_addr, pc_seq, br_target, pc_next;

	function automatic logic cond_check(input logic [3:0] c, input flags_t f);
		logic n, z, cf, v;
		n = f[FLAG_N];
		z = f[FLAG_Z];
		cf = f[FLAG_C];
		v = f[FLAG_V];
		case (c)
			4'h0: return z;
			4'h1: return !z;
			4'h2: return cf;
			4'h3: return !cf;
			4'h4: return n;
			4'h5: return !n;
			4'h6: return v;
			4'h7: return !v;
			4'h8: return cf && !z;
			4'h9: return !cf || z;
			4'ha: return n == v;
			4'hb: return n != v;
			4'hc: return !z && (n == v);
			4'hd: return z || (n != v);
			4'he: return 1'b1;
			default: return 1'b0;	// nv never runs
		endcase
	endfunction

	assign rn = instr[19:16];
	assign rd = instr[15:12];
	assign ls_p = instr[24];
	assign ls_u = instr[23];
	assign ls_w = instr[21];
	assign ls_l = instr[20];
	assign rd_is_pc = rd == reg_idx_t'(`CPU_NREGS - 1);
	assign cond_ok = cond_check(instr[31:28], flags);

	// reg-shift and msr/mrs space fall through as no-ops
	assign is_dp = instr[27:26] == 2'b00 && (instr[25] || !instr[4])
		&& !(instr[24:23] == 2'b10 && !instr[20]);
	assign is_br = instr[27:25] == 3'b101;
	assign is_ls = instr[27:25] == 3'b010 && !instr[22];	// word, imm offset
	assign set_flags = is_dp && instr[20] && !rd_is_pc;

	assign off_addr = ls_u ? i_rn_data + word_t'(instr[11:0]) : i_rn_data - word_t'(instr[11:0]);
	assign pc_seq = pc + word_t'(4);
	assign br_target = pc + word_t'(8) + word_t'({{6{instr[23]}}, instr[23:0], 2'b00});

	assign o_rn_addr = rn;
	assign o_rm_addr = instr[3:0];
	assign o_rd_addr = rd;
	assign o_pc = pc;

	assign ex.op = alu_op_t'(instr[24:21]);
	assign ex.op_a = i_rn_data;
	assign ex.rm_val = i_rm_data;
	assign ex.imm_sel = instr[25];
	assign ex.imm8 = instr[7:0];
	assign ex.rot = instr[11:8];
	assign ex.shift_type = shift_t'(instr[6:5]);
	assign ex.shift_amt = instr[11:7];
	assign ex.flags_in = flags;

	always_comb begin
		pc_next = pc_seq;
		if (is_br)
			pc_next = br_target;
		else if (is_dp && ex.writes_rd && rd_is_pc)
			pc_next = ex.result;	// data-processing into pc
		else if (is_ls && ls_l && rd_is_pc)
			pc_next = i_mem_rdata;
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= INIT;
			flags <= '0;
		end else begin
			case (state)
				INIT: begin
					pc <= `CPU_RESET_PC;
					state <= FETCH;
				end
				FETCH: if (i_mem_ok) state <= DECODE;
				DECODE: begin
					if (cond_ok) begin
						state <= EXECUTE;
					end else begin
						pc <= pc_seq;	// skipped instruction
						state <= FETCH;
					end
				end
				default: begin
					if (!is_ls || i_mem_ok) begin
						pc <= pc_next;
						state <= FETCH;
					end
					if (set_flags) flags <= ex.flags_out;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == FETCH && i_mem_ok) instr <= i_mem_rdata;
		if (state == DECODE) ls_addr <= ls_p ? off_addr : i_rn_data;
	end

	// one register write per cycle
	always_comb begin
		o_we = 1'b0;
		o_waddr = rd;
		o_wdata = ex.result;
		if (state == DECODE) begin
			if (cond_ok && is_ls && (!ls_p || ls_w)) begin
				o_we = 1'b1;	// base writeback
				o_waddr = rn;
				o_wdata = off_addr;
			end
		end else if (state == EXECUTE) begin
			if (is_br) begin
				o_we = instr[24];	// bl link
				o_waddr = 4'd14;
				o_wdata = pc_seq;
			end else if (is_dp) begin
				o_we = ex.writes_rd && !rd_is_pc;
			end else if (is_ls) begin
				o_we = ls_l && i_mem_ok && !rd_is_pc;
				o_wdata = i_mem_rdata;
			end
		end
	end

	always_comb begin
		o_mem_addr = '0;
		o_mem_wdata = '0;
		o_mem_read = 1'b0;
		o_mem_write = 1'b0;
		if (state == FETCH) begin
			o_mem_addr = pc;
			o_mem_read = 1'b1;
		end else if (state == EXECUTE && is_ls) begin
			o_mem_addr = ls_addr;
			o_mem_read = ls_l;
			o_mem_write = !ls_l;
			o_mem_wdata = i_rd_data;	// str source
		end
	end

endmodule

`default_nettype wire

// ==== src/cpu_pkg.sv ====
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

	typedef logic [`CPU_XLEN-1:0] word_t;
	typedef logic [3:0] reg_idx_t;
	typedef logic [3:0] flags_t;	// n z c v, n on top

	// bit positions inside flags_t
	localparam int unsigned FLAG_N = 3;
	localparam int unsigned FLAG_Z = 2;
	localparam int unsigned FLAG_C = 1;
	localparam int unsigned FLAG_V = 0;

	// data-processing opcodes, instr[24:21]
	typedef enum logic [3:0] {
		AND = 4'b0000, EOR = 4'b0001, SUB = 4'b0010, RSB = 4'b0011,
		ADD = 4'b0100, ADC = 4'b0101, SBC = 4'b0110, RSC = 4'b0111,
		TST = 4'b1000, TEQ = 4'b1001, CMP = 4'b1010, CMN = 4'b1011,
		ORR = 4'b1100, MOV = 4'b1101, BIC = 4'b1110, MVN = 4'b1111
	} alu_op_t;

	typedef enum logic [1:0] {
		LSL = 2'b00,
		LSR = 2'b01,
		ASR = 2'b10,
		ROR = 2'b11
	} shift_t;

	typedef enum logic [1:0] {
		INIT    = 2'd0,
		FETCH   = 2'd1,
		DECODE  = 2'd2,
		EXECUTE = 2'd3
	} cpu_state_t;

endpackage

`default_nettype wire

// ==== src/cpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
	input  wire logic  clk,
	input  wire logic  rstn,
	output word_t      o_mem_addr,
	output word_t      o_mem_wdata,
	input  wire word_t i_mem_rdata,
	output logic       o_mem_read,
	output logic       o_mem_write,
	input  wire logic  i_mem_ok
);

	reg_idx_t rn_addr;
	reg_idx_t rm_addr;
	reg_idx_t rd_addr;
	word_t    rn_data;
	word_t    rm_data;
	word_t    rd_data;
	logic     we;
	reg_idx_t waddr;
	word_t    wdata;
	word_t    pc;

	exec_if ex_bus ();

	cpu_ctrl u_ctrl (
		.clk(clk), .rstn(rstn),
		.o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata), .i_mem_rdata(i_mem_rdata),
		.o_mem_read(o_mem_read), .o_mem_write(o_mem_write), .i_mem_ok(i_mem_ok),
		.o_rn_addr(rn_addr), .o_rm_addr(rm_addr), .o_rd_addr(rd_addr),
		.i_rn_data(rn_data), .i_rm_data(rm_data), .i_rd_data(rd_data),
		.o_we(we), .o_waddr(waddr), .o_wdata(wdata),
		.o_pc(pc),
		.ex(ex_bus)
	);

	reg_file u_regs (
		.clk(clk),
		.i_rn_addr(rn_addr), .i_rm_addr(rm_addr), .i_rd_addr(rd_addr),
		.o_rn_data(rn_data), .o_rm_data(rm_data), .o_rd_data(rd_data),
		.i_we(we), .i_waddr(waddr), .i_wdata(wdata),
		.i_pc(pc)
	);

	alu_unit u_alu (
		.ex(ex_bus)
	);

endmodule

`default_nettype wire

// ==== src/exec_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface exec_if import cpu_pkg::*;;
	alu_op_t  op;
	word_t    op_a;	// rn value
	word_t    rm_val;
	logic     imm_sel;	// instr[25]
	logic [7:0] imm8;
	logic [3:0] rot;
	shift_t   shift_type;
	logic [4:0] shift_amt;
	flags_t   flags_in;
	word_t    result;
	flags_t   flags_out;
	logic     writes_rd;	// low for tst/teq/cmp/cmn

	modport ctrl (output op, op_a, rm_val, imm_sel, imm8, rot, shift_type, shift_amt, flags_in,
		input result, flags_out, writes_rd);
	modport alu (input op, op_a, rm_val, imm_sel, imm8, rot, shift_type, shift_amt, flags_in,
		output result, flags_out, writes_rd);
endinterface

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_cfg.svh"

module reg_file import cpu_pkg::*; (
	input  wire logic     clk,
	input  wire reg_idx_t i_rn_addr,
	input  wire reg_idx_t i_rm_addr,
	input  wire reg_idx_t i_rd_addr,
	output word_t         o_rn_data,
	output word_t         o_rm_data,
	output word_t         o_rd_data,
	input  wire logic     i_we,
	input  wire reg_idx_t i_waddr,
	input  wire word_t    i_wdata,
	input  wire word_t    i_pc
);

	localparam reg_idx_t PC_IDX = reg_idx_t'(`CPU_NREGS - 1);

	word_t regs [`CPU_NREGS-1];	// r0..r14
	word_t pc_read;

	assign pc_read = i_pc + word_t'(8);	// arm pipeline view of pc

	assign o_rn_data = (i_rn_addr == PC_IDX) ? pc_read : regs[i_rn_addr];
	assign o_rm_data = (i_rm_addr == PC_IDX) ? pc_read : regs[i_rm_addr];
	assign o_rd_data = (i_rd_addr == PC_IDX) ? pc_read : regs[i_rd_addr];

	always_ff @(posedge clk) begin
		if (i_we && i_waddr != PC_IDX) regs[i_waddr] <= i_wdata;
	end

endmodule

`default_nettype wire
